// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= tb_top
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
PASS_TEXT  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/seq_checker.sv ====
module seq_checker #(
    parameter int VLANE_NUM = 8
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                start_i,
    input  lane_seq_pkg::instr_t                instr_i,
    input  logic                                ready_o,
    input  logic                                load_valid_i,
    input  logic                                load_last_i,
    input  logic [VLANE_NUM-1:0][3:0]           load_bwen_i,
    input  logic [lane_seq_pkg::ADDR_W-1:0]     vrf_raddr_o,
    input  logic [lane_seq_pkg::ADDR_W-1:0]     vrf_waddr_o,
    input  logic [VLANE_NUM-1:0][3:0]           vrf_bwen_o,
    input  logic [VLANE_NUM-1:0]                read_data_valid_o,
    input  logic [lane_seq_pkg::CNT_W-1:0]      vmrf_addr_o,
    input  logic                                vmrf_wen_o,
    input  logic                                store_data_valid_o,
    input  logic                                ready_for_load_o,
    output int                                  err_count_o,
    output int                                  rows_done_o
);
    timeunit 1ns;
    timeprecision 1ps;

    lane_seq_pkg::instr_t inst;  // Instruction of the running row
    logic active;
    logic load_done;
    int   cyc;
    int   n;
    int   d;
    int   beat_idx;
    int   row_errs;

    initial begin
        active      = 1'b0;
        err_count_o = 0;
        rows_done_o = 0;
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            err_count_o++;
            row_errs++;
            $display("error %s: expected %h, got %h (row %0d, cycle %0d)",
                     name, exp, act, rows_done_o, cyc);
        end
    endtask

    function automatic int per_word(input lane_seq_pkg::sew_e sew);
        case (sew)
            lane_seq_pkg::SEW_BYTE: return 4;
            lane_seq_pkg::SEW_HALF: return 2;
            default:                return 1;
        endcase
    endfunction

    // Same 4-bit pattern on every lane
    function automatic logic [31:0] spread_bwen(input lane_seq_pkg::sew_e sew, input int k);
        logic [3:0]  p;
        logic [31:0] all;
        case (sew)
            lane_seq_pkg::SEW_BYTE: p = 4'b0001 << (k % 4);
            lane_seq_pkg::SEW_HALF: p = (k % 2 == 0) ? 4'b0011 : 4'b1100;
            default:                p = 4'b1111;
        endcase
        all = '0;
        for (int i = 0; i < VLANE_NUM; i++) begin
            all[i*4 +: 4] = p;
        end
        return all;
    endfunction

    function automatic logic [31:0] lane_mask(input int k);
        logic [31:0] m;
        m = '0;
        for (int i = 0; i < VLANE_NUM; i++) begin
            m[i] = (k * VLANE_NUM + i) < int'(inst.vl);
        end
        return m;
    endfunction

    task automatic check_idle();
        compare("ready_o", 32'd1, 32'(ready_o));
        compare("vrf_bwen_o", 32'd0, 32'(vrf_bwen_o));
        compare("read_data_valid_o", 32'd0, 32'(read_data_valid_o));
        compare("vmrf_wen_o", 32'd0, 32'(vmrf_wen_o));
        compare("ready_for_load_o", 32'd0, 32'(ready_for_load_o));
        compare("store_data_valid_o", 32'd0, 32'(store_data_valid_o));
    endtask

    task automatic finish_row();
        if (row_errs == 0) begin
            $display("row %0d kind %0d ok after %0d cycles", rows_done_o, inst.kind, cyc);
        end else begin
            $display("error row %0d kind %0d: %0d mismatches", rows_done_o, inst.kind, row_errs);
        end
        rows_done_o++;
        active = 1'b0;
    endtask

    ////////////////////
    // Normal and store
    ////////////////////
    task automatic check_vector();
        logic rd;
        logic wr;
        int   last_c;
        int   k;
        rd     = (cyc >= 1) && (cyc <= n);
        wr     = (inst.kind == lane_seq_pkg::INST_NORMAL) && (cyc > d) && (cyc <= n + d);
        last_c = (inst.kind == lane_seq_pkg::INST_NORMAL) ? n + d + 1 : n + 1;
        if (cyc == last_c) begin
            check_idle();
            finish_row();
        end else begin
            compare("ready_o", 32'd0, 32'(ready_o));
            compare("ready_for_load_o", 32'd0, 32'(ready_for_load_o));
            if (rd) begin
                k = cyc - 1;
                compare("vrf_raddr_o", (int'(inst.raddr) + k / per_word(inst.sew)) % 512,
                        32'(vrf_raddr_o));
                compare("read_data_valid_o", lane_mask(k), 32'(read_data_valid_o));
                compare("store_data_valid_o", 32'(inst.kind == lane_seq_pkg::INST_STORE),
                        32'(store_data_valid_o));
            end else begin
                compare("read_data_valid_o", 32'd0, 32'(read_data_valid_o));
                compare("store_data_valid_o", 32'd0, 32'(store_data_valid_o));
            end
            if (wr) begin
                k = cyc - 1 - d;  // Write element index
                compare("vrf_waddr_o", (int'(inst.waddr) + k / per_word(inst.sew)) % 512,
                        32'(vrf_waddr_o));
                compare("vrf_bwen_o", spread_bwen(inst.sew, k), 32'(vrf_bwen_o));
                compare("vmrf_wen_o", 32'(inst.mask_en), 32'(vmrf_wen_o));
                compare("vmrf_addr_o", k, 32'(vmrf_addr_o));
            end else begin
                compare("vrf_bwen_o", 32'd0, 32'(vrf_bwen_o));
                compare("vmrf_wen_o", 32'd0, 32'(vmrf_wen_o));
            end
        end
    endtask

    ////////////////////
    // Load
    ////////////////////
    task automatic check_load();
        if (load_done) begin
            check_idle();  // Cycle after the last beat
            finish_row();
        end else begin
            compare("ready_o", 32'd0, 32'(ready_o));
            compare("read_data_valid_o", 32'd0, 32'(read_data_valid_o));
            compare("store_data_valid_o", 32'd0, 32'(store_data_valid_o));
            compare("ready_for_load_o", 32'(cyc >= 1), 32'(ready_for_load_o));
            if ((cyc >= 1) && load_valid_i) begin
                compare("vrf_waddr_o", (int'(inst.waddr) + beat_idx) % 512, 32'(vrf_waddr_o));
                compare("vrf_bwen_o", 32'(load_bwen_i), 32'(vrf_bwen_o));
                compare("vmrf_wen_o", 32'(inst.mask_en), 32'(vmrf_wen_o));
                beat_idx++;
                if (load_last_i) begin
                    load_done = 1'b1;
                end
            end else begin
                compare("vrf_bwen_o", 32'd0, 32'(vrf_bwen_o));
                compare("vmrf_wen_o", 32'd0, 32'(vmrf_wen_o));
            end
        end
    endtask

    // Mid-cycle sampling, inputs and outputs both settled
    always @(negedge clk_i) begin
        if (!rst_i) begin
            active = 1'b0;
        end else begin
            if (active) begin
                cyc++;
                if (inst.kind == lane_seq_pkg::INST_LOAD) begin
                    check_load();
                end else begin
                    check_vector();
                end
            end else begin
                check_idle();
            end
            if (!active && start_i && ready_o) begin  // Accepted at the next edge
                inst      = instr_i;
                n         = (int'(instr_i.vl) + VLANE_NUM - 1) / VLANE_NUM;
                d         = int'(instr_i.delay);
                cyc       = -1;
                beat_idx  = 0;
                load_done = 1'b0;
                row_errs  = 0;
                active    = 1'b1;
            end
        end
    end

endmodule

// ==== bench/tb_top.sv ====
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int VLANE_NUM = 8;
    localparam int NUM_ROWS  = 9;
    localparam int VL_W      = lane_seq_pkg::VL_W;
    localparam int CNT_W     = lane_seq_pkg::CNT_W;
    localparam int ADDR_W    = lane_seq_pkg::ADDR_W;

    typedef struct packed {
        lane_seq_pkg::inst_e kind;
        lane_seq_pkg::sew_e  sew;
        int                  vl;
        int                  delay;
        int                  waddr;
        int                  raddr;
        logic                mask_en;
        int                  beats;   // Load rows only
    } row_t;

    logic                      clk_i;
    logic                      rst_i;
    logic                      start_i;
    lane_seq_pkg::instr_t      instr_i;
    logic                      ready_o;
    logic                      load_valid_i;
    logic                      load_last_i;
    logic [VLANE_NUM-1:0][3:0] load_bwen_i;
    logic                      ready_for_load_o;
    logic [ADDR_W-1:0]         vrf_raddr_o;
    logic [ADDR_W-1:0]         vrf_waddr_o;
    logic [VLANE_NUM-1:0][3:0] vrf_bwen_o;
    logic [VLANE_NUM-1:0]      read_data_valid_o;
    logic [CNT_W-1:0]          vmrf_addr_o;
    logic                      vmrf_wen_o;
    logic                      store_data_valid_o;
    int                        err_count;
    int                        rows_done;

    row_t        rows_tbl [NUM_ROWS];
    logic [31:0] lfsr_q;
    int          cycle_count;
    int          cycle_limit;

    lane_seq_top #(.VLANE_NUM(VLANE_NUM)) dut0 (.*);

    seq_checker #(.VLANE_NUM(VLANE_NUM)) checker0 (
        .*,
        .err_count_o(err_count),
        .rows_done_o(rows_done)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    function automatic row_t make_row(input lane_seq_pkg::inst_e kind,
                                      input lane_seq_pkg::sew_e sew, input int vl,
                                      input int delay, input int waddr, input int raddr,
                                      input logic mask_en, input int beats);
        row_t r;
        r.kind    = kind;
        r.sew     = sew;
        r.vl      = vl;
        r.delay   = delay;
        r.waddr   = waddr;
        r.raddr   = raddr;
        r.mask_en = mask_en;
        r.beats   = beats;
        return r;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b      = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
    endtask

    // Beat or gap for this cycle, gaps about one in four
    task automatic drive_load(input int beats_left);
        logic b0;
        logic b1;
        logic [31:0] en;
        take_bit(b0);
        take_bit(b1);
        load_valid_i = b0 | b1;
        load_last_i  = (b0 | b1) && (beats_left == 1);
        for (int i = 0; i < 32; i++) begin
            take_bit(en[i]);
        end
        load_bwen_i = en;
    endtask

    task automatic run_row(input row_t r);
        int c;
        int beats_left;
        instr_i.kind    = r.kind;
        instr_i.sew     = r.sew;
        instr_i.vl      = VL_W'(r.vl);
        instr_i.delay   = CNT_W'(r.delay);
        instr_i.waddr   = ADDR_W'(r.waddr);
        instr_i.raddr   = ADDR_W'(r.raddr);
        instr_i.mask_en = r.mask_en;
        start_i         = 1'b1;
        @(posedge clk_i);
        #5;
        start_i    = 1'b0;
        c          = 0;
        beats_left = r.beats;
        while (!ready_o) begin
            if (c == 2) begin
                // Busy start with a foreign instruction, must be ignored
                start_i       = 1'b1;
                instr_i.kind  = lane_seq_pkg::INST_STORE;
                instr_i.vl    = VL_W'(99);
                instr_i.raddr = ADDR_W'(7);
            end else begin
                start_i = 1'b0;
            end
            if ((r.kind == lane_seq_pkg::INST_LOAD) && ready_for_load_o && (beats_left > 0)) begin
                drive_load(beats_left);
            end else begin
                load_valid_i = 1'b0;
                load_last_i  = 1'b0;
            end
            @(posedge clk_i);
            #5;
            if (load_valid_i) begin
                beats_left--;
            end
            c++;
        end
        start_i      = 1'b0;
        load_valid_i = 1'b0;
        load_last_i  = 1'b0;
        load_bwen_i  = '0;
    endtask

    ////////////////////
    // Run limit
    ////////////////////
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        rows_tbl[0] = make_row(lane_seq_pkg::INST_NORMAL, lane_seq_pkg::SEW_WORD, 16, 2,
                               10, 40, 1'b0, 0);
        rows_tbl[1] = make_row(lane_seq_pkg::INST_NORMAL, lane_seq_pkg::SEW_BYTE, 20, 1,
                               100, 200, 1'b1, 0);
        rows_tbl[2] = make_row(lane_seq_pkg::INST_STORE, lane_seq_pkg::SEW_HALF, 40, 0,
                               0, 300, 1'b0, 0);
        rows_tbl[3] = make_row(lane_seq_pkg::INST_LOAD, lane_seq_pkg::SEW_WORD, 0, 0,
                               50, 0, 1'b0, 6);
        rows_tbl[4] = make_row(lane_seq_pkg::INST_NORMAL, lane_seq_pkg::SEW_BYTE, 61, 3,
                               120, 250, 1'b1, 0);
        rows_tbl[5] = make_row(lane_seq_pkg::INST_NORMAL, lane_seq_pkg::SEW_HALF, 64, 4,
                               400, 5, 1'b1, 0);
        rows_tbl[6] = make_row(lane_seq_pkg::INST_LOAD, lane_seq_pkg::SEW_BYTE, 0, 0,
                               480, 0, 1'b0, 3);
        rows_tbl[7] = make_row(lane_seq_pkg::INST_STORE, lane_seq_pkg::SEW_BYTE, 9, 0,
                               0, 77, 1'b0, 0);
        rows_tbl[8] = make_row(lane_seq_pkg::INST_NORMAL, lane_seq_pkg::SEW_WORD, 1, 1,
                               33, 66, 1'b1, 0);
        cycle_count = 0;
        cycle_limit = 5 + 10;  // Reset and drain
        for (int i = 0; i < NUM_ROWS; i++) begin
            cycle_limit += (rows_tbl[i].vl + VLANE_NUM - 1) / VLANE_NUM
                           + rows_tbl[i].delay + rows_tbl[i].beats + 20;
        end
        lfsr_q       = 32'h72bd_225b;
        rst_i        = 1'b0;
        start_i      = 1'b0;
        instr_i      = '0;
        load_valid_i = 1'b0;
        load_last_i  = 1'b0;
        load_bwen_i  = '0;
        repeat (5) @(posedge clk_i);
        #5;
        rst_i = 1'b1;
        @(posedge clk_i);
        #5;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows_tbl[i]);
        end
        repeat (2) @(posedge clk_i);
        $display("rows checked %0d of %0d, errors %0d", rows_done, NUM_ROWS, err_count);
        if ((err_count == 0) && (rows_done == NUM_ROWS)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
verilog/lane_seq_pkg.sv
verilog/vrf_addr_counter.sv
verilog/bwen_gen.sv
verilog/lane_valid_gen.sv
verilog/seq_fsm.sv
verilog/lane_seq_top.sv
bench/seq_checker.sv
bench/tb_top.sv

// ==== verilog/bwen_gen.sv ====
module bwen_gen #(
    parameter int VLANE_NUM = 8
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  lane_seq_pkg::seq_ctrl_t     ctrl_i,
    input  logic                        load_beat_i,
    input  logic [VLANE_NUM-1:0][3:0]   load_bwen_i,
    output logic [VLANE_NUM-1:0][3:0]   bwen_o
);

    logic [3:0] rot4_q;  // Byte one-hot
    logic [1:0] rot2_q;  // Halfword one-hot
    logic [3:0] pattern;

    ////////////////////
    // Rotating one-hots
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rot4_q <= 4'b0001;
            rot2_q <= 2'b01;
        end else if (ctrl_i.wr_active) begin
            rot4_q <= {rot4_q[2:0], rot4_q[3]};
            rot2_q <= {rot2_q[0], rot2_q[1]};
        end else begin
            rot4_q <= 4'b0001;  // Back to byte 0 between writes
            rot2_q <= 2'b01;
        end
    end

    always_comb begin
        case (ctrl_i.wr_sew)
            lane_seq_pkg::SEW_BYTE: pattern = rot4_q;
            lane_seq_pkg::SEW_HALF: pattern = {{2{rot2_q[1]}}, {2{rot2_q[0]}}};
            lane_seq_pkg::SEW_WORD: pattern = 4'b1111;
            default:                pattern = 4'b0000;
        endcase
    end

    ////////////////////
    // Lane fan-out
    ////////////////////
    always_comb begin
        for (int i = 0; i < VLANE_NUM; i++) begin
            if (ctrl_i.ld_active && load_beat_i) begin
                bwen_o[i] = load_bwen_i[i];  // Load data carries its own enables
            end else if (ctrl_i.wr_active) begin
                bwen_o[i] = pattern;
            end else begin
                bwen_o[i] = 4'b0000;
            end
        end
    end

endmodule

// ==== verilog/lane_seq_pkg.sv ====
package lane_seq_pkg;

    ////////////////////
    // Sizing constants
    ////////////////////
    localparam int VLANE_NUM       = 8;
    localparam int MAX_VL_PER_LANE = 256;  // Elements held by one lane
    localparam int MEM_DEPTH       = 512;  // Register file words per lane

    localparam int VL_W   = $clog2(VLANE_NUM * MAX_VL_PER_LANE + 1);
    localparam int CNT_W  = $clog2(MAX_VL_PER_LANE + 1);
    localparam int ADDR_W = $clog2(MEM_DEPTH);

    ////////////////////
    // Encodings
    ////////////////////
    typedef enum logic [1:0] {
        SEW_BYTE = 2'd0,
        SEW_HALF = 2'd1,
        SEW_WORD = 2'd2
    } sew_e;

    typedef enum logic [1:0] {
        INST_NORMAL = 2'd0,  // Read, ALU, write back
        INST_STORE  = 2'd1,  // Unit-stride store, read side only
        INST_LOAD   = 2'd2   // Unit-stride load, write side only
    } inst_e;

    // Instruction as presented with start
    typedef struct packed {
        inst_e             kind;
        sew_e              sew;
        logic [VL_W-1:0]   vl;
        logic [CNT_W-1:0]  delay;      // ALU latency in cycles
        logic [ADDR_W-1:0] waddr;
        logic [ADDR_W-1:0] raddr;
        logic              mask_en;    // Result also goes to the mask register
    } instr_t;

    // Per-cycle control from the FSM to the datapath
    typedef struct packed {
        logic rd_active;  // Read element this cycle
        logic wr_active;  // Register file write this cycle, load beats included
        logic ld_active;  // Load phase, beats accepted
        logic clear;      // First cycle after accept
        sew_e wr_sew;
        sew_e rd_sew;
    } seq_ctrl_t;

endpackage

// ==== verilog/lane_seq_top.sv ====
module lane_seq_top #(
    parameter int VLANE_NUM       = lane_seq_pkg::VLANE_NUM,
    parameter int MAX_VL_PER_LANE = lane_seq_pkg::MAX_VL_PER_LANE
) (
    input  logic                                clk_i,
    input  logic                                rst_i,

    // Instruction handshake
    input  logic                                start_i,
    input  lane_seq_pkg::instr_t                instr_i,
    output logic                                ready_o,

    // Load side
    input  logic                                load_valid_i,
    input  logic                                load_last_i,
    input  logic [VLANE_NUM-1:0][3:0]           load_bwen_i,
    output logic                                ready_for_load_o,

    // Vector register file
    output logic [lane_seq_pkg::ADDR_W-1:0]     vrf_raddr_o,
    output logic [lane_seq_pkg::ADDR_W-1:0]     vrf_waddr_o,
    output logic [VLANE_NUM-1:0][3:0]           vrf_bwen_o,
    output logic [VLANE_NUM-1:0]                read_data_valid_o,

    // Mask register file
    output logic [lane_seq_pkg::CNT_W-1:0]      vmrf_addr_o,
    output logic                                vmrf_wen_o,

    // Store side
    output logic                                store_data_valid_o
);

    lane_seq_pkg::instr_t    instr_q;
    lane_seq_pkg::seq_ctrl_t ctrl;

    assign vmrf_wen_o = ctrl.wr_active & instr_q.mask_en;  // Mask write rides on VRF write

    ////////////////////
    // Sequencer
    ////////////////////
    seq_fsm #(
        .VLANE_NUM         (VLANE_NUM),
        .MAX_VL_PER_LANE   (MAX_VL_PER_LANE)
    ) fsm0 (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .start_i           (start_i),
        .instr_i           (instr_i),
        .load_valid_i      (load_valid_i),
        .load_last_i       (load_last_i),
        .ready_o           (ready_o),
        .instr_o           (instr_q),
        .ctrl_o            (ctrl),
        .elem_o            (vmrf_addr_o),
        .store_data_valid_o(store_data_valid_o),
        .ready_for_load_o  (ready_for_load_o)
    );

    ////////////////////
    // Address counters
    ////////////////////
    vrf_addr_counter rd_addr0 (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .clear_i     (ctrl.clear),
        .en_i        (ctrl.rd_active),
        .sew_i       (ctrl.rd_sew),
        .start_addr_i(instr_q.raddr),
        .addr_o      (vrf_raddr_o)
    );

    vrf_addr_counter wr_addr0 (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .clear_i     (ctrl.clear),
        .en_i        (ctrl.wr_active),  // Also steps once per load beat
        .sew_i       (ctrl.wr_sew),
        .start_addr_i(instr_q.waddr),
        .addr_o      (vrf_waddr_o)
    );

    ////////////////////
    // Lane side
    ////////////////////
    bwen_gen #(
        .VLANE_NUM  (VLANE_NUM)
    ) bwen0 (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .ctrl_i     (ctrl),
        .load_beat_i(load_valid_i),
        .load_bwen_i(load_bwen_i),
        .bwen_o     (vrf_bwen_o)
    );

    lane_valid_gen #(
        .VLANE_NUM(VLANE_NUM)
    ) valid0 (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .ctrl_i   (ctrl),
        .vl_i     (instr_q.vl),
        .valid_o  (read_data_valid_o)
    );

endmodule

// ==== verilog/lane_valid_gen.sv ====
module lane_valid_gen #(
    parameter int VLANE_NUM = 8
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  lane_seq_pkg::seq_ctrl_t         ctrl_i,
    input  logic [lane_seq_pkg::VL_W-1:0]   vl_i,
    output logic [VLANE_NUM-1:0]            valid_o
);

    localparam int VL_W = lane_seq_pkg::VL_W;

    logic [VL_W-1:0] rem_q;  // Elements not yet read

    ////////////////////
    // Remaining count
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rem_q <= '0;
        end else if (ctrl_i.clear) begin
            rem_q <= vl_i;
        end else if (ctrl_i.rd_active) begin
            // One row of VLANE_NUM elements per read cycle
            if (rem_q > VL_W'(VLANE_NUM)) begin
                rem_q <= rem_q - VL_W'(VLANE_NUM);
            end else begin
                rem_q <= '0;
            end
        end
    end

    // Ragged last row leaves the upper lanes idle
    always_comb begin
        for (int i = 0; i < VLANE_NUM; i++) begin
            valid_o[i] = ctrl_i.rd_active && (rem_q > VL_W'(i));
        end
    end

endmodule

// ==== verilog/seq_fsm.sv ====
module seq_fsm #(
    parameter int VLANE_NUM       = 8,
    parameter int MAX_VL_PER_LANE = 256
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            start_i,
    input  lane_seq_pkg::instr_t            instr_i,
    input  logic                            load_valid_i,
    input  logic                            load_last_i,
    output logic                            ready_o,
    output lane_seq_pkg::instr_t            instr_o,
    output lane_seq_pkg::seq_ctrl_t         ctrl_o,
    output logic [lane_seq_pkg::CNT_W-1:0]  elem_o,
    output logic                            store_data_valid_o,
    output logic                            ready_for_load_o
);

    localparam int N_W   = $clog2(MAX_VL_PER_LANE + 1);   // Elements per lane
    localparam int VLX_W = lane_seq_pkg::VL_W + 1;
    localparam int CYC_W = ((N_W > lane_seq_pkg::CNT_W) ? N_W : lane_seq_pkg::CNT_W) + 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_NORM,   // Read and write phases overlap by the ALU delay
        S_STORE,
        S_LOAD
    } state_e;

    state_e                         state_q;
    lane_seq_pkg::instr_t           instr_q;
    logic [N_W-1:0]                 n_q;
    logic [N_W-1:0]                 n_calc;
    logic [VLX_W-1:0]               vl_round;
    logic [CYC_W-1:0]               cyc_q;
    logic [CYC_W-1:0]               rd_end;
    logic [CYC_W-1:0]               wr_end;
    logic [lane_seq_pkg::CNT_W-1:0] elem_q;
    logic                           accept;
    logic                           setup;
    logic                           rd_act;
    logic                           wr_act;
    logic                           ld_act;
    logic                           ld_beat;
    logic                           done;

    assign accept = start_i & ready_o;

    // Rows per lane, rounded up
    assign vl_round = {1'b0, instr_i.vl} + VLX_W'(VLANE_NUM - 1);
    assign n_calc   = N_W'(vl_round >> $clog2(VLANE_NUM));

    ////////////////////
    // Phase decode
    ////////////////////
    assign rd_end  = CYC_W'(n_q);
    assign wr_end  = CYC_W'(n_q) + CYC_W'(instr_q.delay);
    assign setup   = (state_q != S_IDLE) && (cyc_q == '0);
    assign rd_act  = ((state_q == S_NORM) || (state_q == S_STORE)) && !setup
                     && (cyc_q <= rd_end);
    assign wr_act  = (state_q == S_NORM) && (cyc_q > CYC_W'(instr_q.delay))
                     && (cyc_q <= wr_end);
    assign ld_act  = (state_q == S_LOAD) && !setup;
    assign ld_beat = ld_act & load_valid_i;

    always_comb begin
        case (state_q)
            S_NORM:  done = (cyc_q == wr_end);
            S_STORE: done = (cyc_q == rd_end);
            S_LOAD:  done = ld_beat & load_last_i;  // Last beat closes the load
            default: done = 1'b0;
        endcase
    end

    always_comb begin
        ctrl_o.rd_active = rd_act;
        ctrl_o.wr_active = wr_act | ld_beat;
        ctrl_o.ld_active = ld_act;
        ctrl_o.clear     = setup;
        ctrl_o.rd_sew    = instr_q.sew;
        ctrl_o.wr_sew    = (state_q == S_LOAD) ? lane_seq_pkg::SEW_WORD : instr_q.sew;
    end

    assign instr_o            = instr_q;
    assign elem_o             = elem_q;
    assign store_data_valid_o = rd_act && (state_q == S_STORE);
    assign ready_for_load_o   = ld_act;

    ////////////////////
    // State and handshake
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= S_IDLE;
            ready_o <= 1'b1;
            cyc_q   <= '0;
        end else if (accept) begin
            ready_o <= 1'b0;
            cyc_q   <= '0;
            case (instr_i.kind)
                lane_seq_pkg::INST_NORMAL: state_q <= S_NORM;
                lane_seq_pkg::INST_STORE:  state_q <= S_STORE;
                lane_seq_pkg::INST_LOAD:   state_q <= S_LOAD;
                default: begin
                    state_q <= S_IDLE;
                    ready_o <= 1'b1;
                end
            endcase
        end else if (done) begin
            state_q <= S_IDLE;
            ready_o <= 1'b1;
        end else if ((state_q != S_IDLE) && ((state_q != S_LOAD) || setup)) begin
            cyc_q <= cyc_q + 1'b1;  // Load only needs the setup step
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            instr_q <= instr_i;
            n_q     <= n_calc;
        end
    end

    // Write element index, doubles as mask address
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            elem_q <= '0;
        end else if (setup) begin
            elem_q <= '0;
        end else if (ctrl_o.wr_active) begin
            elem_q <= elem_q + 1'b1;
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    a_kind_known: assert property (@(posedge clk_i) disable iff (!rst_i)
        accept |-> instr_i.kind inside {lane_seq_pkg::INST_NORMAL,
                                        lane_seq_pkg::INST_STORE,
                                        lane_seq_pkg::INST_LOAD});

    // Busy phases never overlap an open handshake
    a_ready_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        ready_o |-> !(rd_act || ctrl_o.wr_active || ld_act));

endmodule

// ==== verilog/vrf_addr_counter.sv ====
module vrf_addr_counter (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             clear_i,
    input  logic                             en_i,
    input  lane_seq_pkg::sew_e               sew_i,
    input  logic [lane_seq_pkg::ADDR_W-1:0]  start_addr_i,
    output logic [lane_seq_pkg::ADDR_W-1:0]  addr_o
);

    logic [1:0]                      sub_q;   // Element within the current word
    logic [1:0]                      sub_last;
    logic                            word_done;
    logic [lane_seq_pkg::ADDR_W-1:0] addr_q;

    always_comb begin
        case (sew_i)
            lane_seq_pkg::SEW_BYTE: sub_last = 2'd3;
            lane_seq_pkg::SEW_HALF: sub_last = 2'd1;
            default:                sub_last = 2'd0;  // One word element per word
        endcase
    end

    assign word_done = en_i && (sub_q == sub_last);
    assign addr_o    = addr_q;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            sub_q  <= '0;
            addr_q <= '0;
        end else if (clear_i) begin
            sub_q  <= '0;
            addr_q <= start_addr_i;
        end else if (word_done) begin
            sub_q  <= '0;
            addr_q <= addr_q + 1'b1;
        end else if (en_i) begin
            sub_q  <= sub_q + 1'b1;
        end
    end

    // A step never wraps past the last word
    a_addr_range: assert property (@(posedge clk_i) disable iff (!rst_i)
        (word_done && !clear_i) |-> (int'(addr_q) < lane_seq_pkg::MEM_DEPTH - 1));

endmodule
